// ==== all.f ====
+incdir+common
common/boot_pkg.sv
flash/flash_reader.sv
boot/bootloader.sv
verilog/ram_arbiter.sv
verilog/word_ram.sv
verilog/seg_decoder.sv
verilog/boot_top.sv
sim/tb_clock.sv
sim/flash_model.sv
sim/boot_top_tb.sv

// ==== boot/bootloader.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "boot_params.svh"

module bootloader import boot_pkg::*; (
	input  wire         clk,
	input  wire         reset,
	output logic        flash_req_valid,
	input  wire         flash_req_ready,
	output flash_addr_t flash_req_addr,
	input  wire         flash_rsp_valid,
	input  word_t       flash_rsp_data,
	output logic        boot_wr_valid,
	output ram_addr_t   boot_wr_addr,
	output word_t       boot_wr_data,
	output logic        boot_done
);

	boot_state_t state;
	ram_addr_t count;
	logic waiting;
	word_t data_q;

	assign boot_wr_valid = (state == BOOT_WRITE);
	assign boot_wr_addr = count;
	assign boot_wr_data = data_q;
	assign boot_done = (state == BOOT_DONE);
	assign flash_req_addr = flash_addr_t'(`BOOT_FLASH_BASE) + flash_addr_t'(count);

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= BOOT_READ;
			count <= '0;
			waiting <= 1'b0;
			flash_req_valid <= 1'b0;
		end else begin
			case (state)
				BOOT_READ: begin
					// First request after reset
					if (!flash_req_valid && !waiting) begin
						flash_req_valid <= 1'b1;
					end
					if (flash_req_valid && flash_req_ready) begin
						flash_req_valid <= 1'b0;
						waiting <= 1'b1;
					end
					if (flash_rsp_valid) begin
						waiting <= 1'b0;
						state <= BOOT_WRITE;
					end
				end
				BOOT_WRITE: begin
					if (count == ram_addr_t'(`BOOT_WORDS - 1)) begin
						state <= BOOT_DONE;
					end else begin
						// Next request goes out in the following cycle
						state <= BOOT_READ;
						count <= count + 1'b1;
						flash_req_valid <= 1'b1;
					end
				end
				BOOT_DONE: begin
					state <= BOOT_DONE;
				end
				default: begin
					state <= BOOT_DONE;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (flash_rsp_valid) begin
			data_q <= flash_rsp_data;
		end
	end

	assert property (@(posedge clk) disable iff (reset)
		boot_wr_valid |-> (boot_wr_addr < ram_addr_t'(`BOOT_WORDS)))
		else $error("boot write beyond image length");

endmodule

`default_nettype wire

// ==== common/boot_params.svh ====
`ifndef BOOT_PARAMS_SVH
`define BOOT_PARAMS_SVH

// Flash read timing, cycles of oe low
`define FLASH_WAIT 3

// Boot image
`define BOOT_WORDS 16
`define BOOT_FLASH_BASE 0

// Address widths
`define RAM_AW 8
`define FLASH_AW 22

`endif

// ==== common/boot_pkg.sv ====
`default_nettype none
`include "boot_params.svh"

package boot_pkg;

	typedef logic [15:0] word_t;
	typedef logic [`RAM_AW-1:0] ram_addr_t;
	typedef logic [`FLASH_AW-1:0] flash_addr_t;

	// Flash read sequencer
	typedef enum logic [1:0] {
		FL_IDLE,
		FL_WAIT,
		FL_DONE
	} flash_state_t;

	// Boot copy sequencer
	typedef enum logic [1:0] {
		BOOT_READ,
		BOOT_WRITE,
		BOOT_DONE
	} boot_state_t;

endpackage

`default_nettype wire

// ==== flash/flash_reader.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "boot_params.svh"

module flash_reader import boot_pkg::*; (
	input  wire         clk,
	input  wire         reset,
	input  wire         req_valid,
	output logic        req_ready,
	input  flash_addr_t req_addr,
	output logic        rsp_valid,
	output word_t       rsp_data,
	output flash_addr_t flash_addr,
	input  word_t       flash_data,
	output logic        flash_ce,
	output logic        flash_oe
);

	flash_state_t state;
	logic [3:0] wait_cnt;
	logic last_wait;

	assign req_ready = (state == FL_IDLE);
	assign rsp_valid = (state == FL_DONE);
	assign last_wait = (state == FL_WAIT) && (wait_cnt == 4'(`FLASH_WAIT - 1));

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= FL_IDLE;
			wait_cnt <= '0;
			flash_ce <= 1'b1;
			flash_oe <= 1'b1;
		end else begin
			case (state)
				FL_IDLE: begin
					if (req_valid) begin
						state <= FL_WAIT;
						wait_cnt <= '0;
						flash_ce <= 1'b0;
						flash_oe <= 1'b0;
					end
				end
				FL_WAIT: begin
					// Release the chip right after the sampling edge
					if (last_wait) begin
						state <= FL_DONE;
						flash_ce <= 1'b1;
						flash_oe <= 1'b1;
					end else begin
						wait_cnt <= wait_cnt + 4'd1;
					end
				end
				FL_DONE: begin
					state <= FL_IDLE;
				end
				default: begin
					state <= FL_IDLE;
				end
			endcase
		end
	end

	// Address held for the whole window
	always_ff @(posedge clk) begin
		if (req_valid && req_ready) begin
			flash_addr <= req_addr;
		end
		if (last_wait) begin
			rsp_data <= flash_data;
		end
	end

	assert property (@(posedge clk) disable iff (reset) !flash_oe |-> !flash_ce)
		else $error("flash_oe low while flash_ce high");

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module boot_top_tb \
	-f all.f -o boot_top_sim &&
./obj_dir/boot_top_sim || { echo "Simulation failed"; exit 1; }

// ==== sim/boot_top_tb.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "boot_params.svh"

module boot_top_tb import boot_pkg::*; ();

	localparam int RESET_CYCLES = 5;
	localparam int HOST_ACCESSES = 200;
	localparam int BOOT_CYCLES = `BOOT_WORDS * (`FLASH_WAIT + 3);
	// 16 boot words of 6 cycles, 216 host accesses of at most 5 cycles, plus margin
	localparam int TIMEOUT_CYCLES = 2000;
	localparam logic [31:0] LFSR_SEED = 32'h91f0_dcca;

	logic clk;
	logic reset;
	flash_addr_t flash_addr;
	word_t flash_data;
	logic flash_ce;
	logic flash_oe;
	logic host_valid;
	logic host_ready;
	logic host_write;
	ram_addr_t host_addr;
	word_t host_wdata;
	logic host_rvalid;
	word_t host_rdata;
	logic boot_done;
	logic [6:0] seg1;
	logic [6:0] seg2;

	logic host_fire;
	logic rd_fire;
	logic rd_expected;
	word_t exp_rdata;
	ram_addr_t last_addr;
	word_t mirror [0:(1 << `RAM_AW) - 1];
	int cycle_count = 0;
	int accept_cycle;
	int oe_run;
	int windows;
	logic seen_low;
	logic [31:0] lfsr;
	ram_addr_t recent [16];
	int recent_ptr;

	tb_clock u_clock (.clk(clk));

	flash_model u_flash (.addr(flash_addr), .ce(flash_ce), .oe(flash_oe), .data(flash_data));

	boot_top u_dut (
		.clk(clk),
		.reset(reset),
		.flash_addr(flash_addr),
		.flash_data(flash_data),
		.flash_ce(flash_ce),
		.flash_oe(flash_oe),
		.host_valid(host_valid),
		.host_ready(host_ready),
		.host_write(host_write),
		.host_addr(host_addr),
		.host_wdata(host_wdata),
		.host_rvalid(host_rvalid),
		.host_rdata(host_rdata),
		.boot_done(boot_done),
		.seg1(seg1),
		.seg2(seg2)
	);

	assign host_fire = host_valid && host_ready;
	assign rd_fire = host_fire && !host_write;

	function automatic word_t flash_content(input int addr);
		return word_t'(addr) ^ 16'h5a3c;
	endfunction

	function automatic logic [6:0] seg_pattern(input logic [3:0] nibble);
		case (nibble)
			4'h0: return 7'h3f;
			4'h1: return 7'h06;
			4'h2: return 7'h5b;
			4'h3: return 7'h4f;
			4'h4: return 7'h66;
			4'h5: return 7'h6d;
			4'h6: return 7'h7d;
			4'h7: return 7'h07;
			4'h8: return 7'h7f;
			4'h9: return 7'h6f;
			4'ha: return 7'h77;
			4'hb: return 7'h7c;
			4'hc: return 7'h39;
			4'hd: return 7'h5e;
			4'he: return 7'h79;
			default: return 7'h71;
		endcase
	endfunction

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic take_bits(input int n, output logic [31:0] bits);
		bits = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			bits = {bits[30:0], lfsr[0]};
		end
	endtask

	task automatic report_mismatch(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		$display("CHECK FAILED %s got 0x%0h expected 0x%0h", name, got, exp);
		$display("STATUS: FAIL");
		$fatal(1, "value mismatch on %s", name);
	endtask

	task automatic report_failure(input string what);
		$display("%s", what);
		$display("STATUS: FAIL");
		$fatal(1, "%s", what);
	endtask

	// Holds valid until ready is seen mid-cycle, then lets the next edge accept
	task automatic host_access(input logic write, input ram_addr_t addr, input word_t data);
		host_valid = 1'b1;
		host_write = write;
		host_addr = addr;
		host_wdata = data;
		while (!host_ready) begin
			@(posedge clk);
			#1;
		end
		@(posedge clk);
		#1;
		host_valid = 1'b0;
	endtask

	// Reference model of flash windows, RAM content and display
	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (reset) begin
			oe_run <= 0;
			windows <= 0;
			seen_low <= 1'b0;
			accept_cycle <= 0;
			rd_expected <= 1'b0;
			exp_rdata <= '0;
			last_addr <= '0;
			for (int i = 0; i < `BOOT_WORDS; i++) begin
				mirror[i] <= flash_content(`BOOT_FLASH_BASE + i);
			end
		end else begin
			if (!flash_oe) begin
				oe_run <= oe_run + 1;
				if (!seen_low) begin
					seen_low <= 1'b1;
					// oe falls on the edge that accepts the request
					accept_cycle <= cycle_count - 1;
				end
			end else begin
				oe_run <= 0;
				if (oe_run != 0) begin
					windows <= windows + 1;
				end
			end
			rd_expected <= rd_fire;
			if (host_fire) begin
				last_addr <= host_addr;
				if (host_write) begin
					mirror[host_addr] <= host_wdata;
				end else begin
					exp_rdata <= mirror[host_addr];
				end
			end
		end
	end

	always @(posedge clk) begin
		if (cycle_count >= TIMEOUT_CYCLES) begin
			report_failure("Timeout, the run did not finish in time");
		end
	end

	assert property (@(posedge clk) $fell(reset) |->
		flash_ce && flash_oe && !boot_done && !host_ready && !host_rvalid)
		else report_failure("Outputs not idle right after reset");

	assert property (@(posedge clk) disable iff (reset) !flash_oe |-> !flash_ce)
		else report_failure("flash_oe low while flash_ce high");

	assert property (@(posedge clk) disable iff (reset)
		!flash_oe |-> flash_addr == flash_addr_t'(`BOOT_FLASH_BASE + windows))
		else report_mismatch("flash_addr", 32'($sampled(flash_addr)),
			32'(`BOOT_FLASH_BASE + $sampled(windows)));

	assert property (@(posedge clk) disable iff (reset) $rose(flash_oe) |-> oe_run == `FLASH_WAIT)
		else report_mismatch("flash_oe low cycles", 32'($sampled(oe_run)), 32'(`FLASH_WAIT));

	assert property (@(posedge clk) disable iff (reset) !flash_oe |-> oe_run < `FLASH_WAIT)
		else report_failure("flash_oe held low past the wait count");

	assert property (@(posedge clk) disable iff (reset)
		$rose(boot_done) |-> cycle_count - accept_cycle == BOOT_CYCLES)
		else report_mismatch("boot_done latency",
			32'($sampled(cycle_count) - $sampled(accept_cycle)), 32'(BOOT_CYCLES));

	assert property (@(posedge clk) disable iff (reset) $rose(boot_done) |-> windows == `BOOT_WORDS)
		else report_mismatch("flash read windows", 32'($sampled(windows)), 32'(`BOOT_WORDS));

	assert property (@(posedge clk) disable iff (reset) boot_done |=> boot_done)
		else report_failure("boot_done dropped after boot");

	assert property (@(posedge clk) disable iff (reset) boot_done |-> host_ready && flash_oe)
		else report_failure("Host locked out or flash still read after boot");

	assert property (@(posedge clk) disable iff (reset) !boot_done |-> !host_ready)
		else report_failure("host_ready high before boot_done");

	assert property (@(posedge clk) disable iff (reset) host_rvalid == rd_expected)
		else report_failure("host_rvalid not exactly one cycle after an accepted read");

	assert property (@(posedge clk) disable iff (reset) host_rvalid |-> host_rdata == exp_rdata)
		else report_mismatch("host_rdata", 32'($sampled(host_rdata)), 32'($sampled(exp_rdata)));

	assert property (@(posedge clk) disable iff (reset)
		host_fire |=> seg1 == seg_pattern(last_addr[7:4]))
		else report_mismatch("seg1", 32'($sampled(seg1)),
			32'(seg_pattern($sampled(last_addr[7:4]))));

	assert property (@(posedge clk) disable iff (reset)
		host_fire |=> seg2 == seg_pattern(last_addr[3:0]))
		else report_mismatch("seg2", 32'($sampled(seg2)),
			32'(seg_pattern($sampled(last_addr[3:0]))));

	initial begin
		logic [31:0] bits;
		ram_addr_t addr;
		int gap;
		reset = 1'b1;
		host_valid = 1'b0;
		host_write = 1'b0;
		host_addr = '0;
		host_wdata = '0;
		lfsr = LFSR_SEED;
		recent_ptr = 0;
		for (int i = 0; i < 16; i++) begin
			recent[i] = ram_addr_t'(i);
		end
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		reset = 1'b0;

		// Boot image read back, the first read waits out the boot
		for (int i = 0; i < `BOOT_WORDS; i++) begin
			host_access(1'b0, ram_addr_t'(i), '0);
		end

		for (int n = 0; n < HOST_ACCESSES; n++) begin
			take_bits(2, bits);
			gap = bits[1] ? 0 : int'(bits[0]) + 1;
			repeat (gap) begin
				@(posedge clk);
				#1;
			end
			take_bits(1, bits);
			if (bits[0]) begin
				take_bits(`RAM_AW, bits);
				addr = bits[`RAM_AW-1:0];
				take_bits(16, bits);
				host_access(1'b1, addr, bits[15:0]);
				recent[recent_ptr] = addr;
				recent_ptr = (recent_ptr + 1) % 16;
			end else begin
				// Reads only go to words with known content
				take_bits(4, bits);
				host_access(1'b0, recent[bits[3:0]], '0);
			end
		end

		repeat (2) @(posedge clk);
		$display("STATUS: PASS");
		$finish;
	end

endmodule

`default_nettype wire

// ==== sim/flash_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module flash_model import boot_pkg::*; (
	input  flash_addr_t addr,
	input  wire         ce,
	input  wire         oe,
	output word_t       data
);

	word_t content;

	// Each word is its own address scrambled with a fixed pattern
	assign content = addr[15:0] ^ 16'h5a3c;

	// Bus floats to zero unless the chip is selected and read
	assign data = (!ce && !oe) ? content : 16'h0000;

endmodule

`default_nettype wire

// ==== sim/tb_clock.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
	output logic clk
);

	// 10 ns period
	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

endmodule

`default_nettype wire

// ==== verilog/boot_top.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "boot_params.svh"

module boot_top import boot_pkg::*; (
	input  wire         clk,
	input  wire         reset,
	output flash_addr_t flash_addr,
	input  word_t       flash_data,
	output logic        flash_ce,
	output logic        flash_oe,
	input  wire         host_valid,
	output logic        host_ready,
	input  wire         host_write,
	input  ram_addr_t   host_addr,
	input  word_t       host_wdata,
	output logic        host_rvalid,
	output word_t       host_rdata,
	output logic        boot_done,
	output logic [6:0]  seg1,
	output logic [6:0]  seg2
);

// Flash
	wire         flash_req_valid;
	wire         flash_req_ready;
	flash_addr_t flash_req_addr;
	wire         flash_rsp_valid;
	word_t       flash_rsp_data;

	flash_reader __flash_reader (
		.clk(clk),
		.reset(reset),
		.req_valid(flash_req_valid),
		.req_ready(flash_req_ready),
		.req_addr(flash_req_addr),
		.rsp_valid(flash_rsp_valid),
		.rsp_data(flash_rsp_data),
		.flash_addr(flash_addr),
		.flash_data(flash_data),
		.flash_ce(flash_ce),
		.flash_oe(flash_oe)
	);

// Bootloader
	wire       boot_wr_valid;
	ram_addr_t boot_wr_addr;
	word_t     boot_wr_data;

	bootloader __bootloader (
		.clk(clk),
		.reset(reset),
		.flash_req_valid(flash_req_valid),
		.flash_req_ready(flash_req_ready),
		.flash_req_addr(flash_req_addr),
		.flash_rsp_valid(flash_rsp_valid),
		.flash_rsp_data(flash_rsp_data),
		.boot_wr_valid(boot_wr_valid),
		.boot_wr_addr(boot_wr_addr),
		.boot_wr_data(boot_wr_data),
		.boot_done(boot_done)
	);

// RAM select
	wire       ram_en;
	wire       ram_we;
	ram_addr_t ram_addr;
	word_t     ram_wdata;
	word_t     ram_rdata;
	ram_addr_t show_addr;

	ram_arbiter __ram_arbiter (
		.clk(clk),
		.reset(reset),
		.boot_wr_valid(boot_wr_valid),
		.boot_wr_addr(boot_wr_addr),
		.boot_wr_data(boot_wr_data),
		.boot_done(boot_done),
		.host_valid(host_valid),
		.host_ready(host_ready),
		.host_write(host_write),
		.host_addr(host_addr),
		.host_wdata(host_wdata),
		.host_rvalid(host_rvalid),
		.host_rdata(host_rdata),
		.ram_en(ram_en),
		.ram_we(ram_we),
		.ram_addr(ram_addr),
		.ram_wdata(ram_wdata),
		.ram_rdata(ram_rdata),
		.show_addr(show_addr)
	);

	word_ram __word_ram (
		.clk(clk),
		.en(ram_en),
		.we(ram_we),
		.addr(ram_addr),
		.wdata(ram_wdata),
		.rdata(ram_rdata)
	);

// Digits, high nibble on the left
	seg_decoder __seg_decoder_1 (
		.nibble(show_addr[7:4]),
		.seg(seg1)
	);

	seg_decoder __seg_decoder_2 (
		.nibble(show_addr[3:0]),
		.seg(seg2)
	);

endmodule

`default_nettype wire

// ==== verilog/ram_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "boot_params.svh"

module ram_arbiter import boot_pkg::*; (
	input  wire       clk,
	input  wire       reset,
	input  wire       boot_wr_valid,
	input  ram_addr_t boot_wr_addr,
	input  word_t     boot_wr_data,
	input  wire       boot_done,
	input  wire       host_valid,
	output logic      host_ready,
	input  wire       host_write,
	input  ram_addr_t host_addr,
	input  word_t     host_wdata,
	output logic      host_rvalid,
	output word_t     host_rdata,
	output logic      ram_en,
	output logic      ram_we,
	output ram_addr_t ram_addr,
	output word_t     ram_wdata,
	input  word_t     ram_rdata,
	output ram_addr_t show_addr
);

	logic host_fire;
	logic rd_pending;

	// Host is locked out until the image is in place
	assign host_ready = boot_done;
	assign host_fire = host_valid && host_ready;

	// Boot writes win
	assign ram_en = boot_wr_valid || host_fire;
	assign ram_we = boot_wr_valid || (host_fire && host_write);
	assign ram_addr = boot_wr_valid ? boot_wr_addr : host_addr;
	assign ram_wdata = boot_wr_valid ? boot_wr_data : host_wdata;

	assign host_rvalid = rd_pending;
	assign host_rdata = ram_rdata;

	always_ff @(posedge clk) begin
		if (reset) begin
			rd_pending <= 1'b0;
			show_addr <= '0;
		end else begin
			rd_pending <= host_fire && !host_write;
			// Display follows the boot address, then the host
			if (ram_en) begin
				show_addr <= ram_addr;
			end
		end
	end

	assert property (@(posedge clk) disable iff (reset)
		(host_fire && !host_write) |=> host_rvalid)
		else $error("host_rvalid missing after accepted read");

	// Bootloader never writes once the host is let in
	assert property (@(posedge clk) disable iff (reset) boot_wr_valid |-> !host_ready)
		else $error("boot write after boot_done");

endmodule

`default_nettype wire

// ==== verilog/seg_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module seg_decoder (
	input  wire  [3:0] nibble,
	output logic [6:0] seg
);

	// gfedcba, segment lit when high
	always_comb begin
		case (nibble)
			4'h0: seg = 7'h3f;
			4'h1: seg = 7'h06;
			4'h2: seg = 7'h5b;
			4'h3: seg = 7'h4f;
			4'h4: seg = 7'h66;
			4'h5: seg = 7'h6d;
			4'h6: seg = 7'h7d;
			4'h7: seg = 7'h07;
			4'h8: seg = 7'h7f;
			4'h9: seg = 7'h6f;
			4'ha: seg = 7'h77;
			4'hb: seg = 7'h7c;
			4'hc: seg = 7'h39;
			4'hd: seg = 7'h5e;
			4'he: seg = 7'h79;
			default: seg = 7'h71;
		endcase
	end

endmodule

`default_nettype wire

// ==== verilog/word_ram.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "boot_params.svh"

module word_ram import boot_pkg::*; (
	input  wire       clk,
	input  wire       en,
	input  wire       we,
	input  ram_addr_t addr,
	input  word_t     wdata,
	output word_t     rdata
);

	word_t mem [0:(1 << `RAM_AW) - 1];

	// Registered read, old data on a write
	always_ff @(posedge clk) begin
		if (en) begin
			if (we) begin
				mem[addr] <= wdata;
			end
			rdata <= mem[addr];
		end
	end

endmodule

`default_nettype wire
